/* replay_store.f */
+incdir+verilog
verilog/replay_pkg.sv
verilog/store_ifs.sv
verilog/ingress_fifo.sv
verilog/fifo_to_mem.sv
verilog/replay_regs.sv
verilog/replay_store.sv
sim/replay_store_tb.sv

/* sim/replay_store_tb.sv */
`default_nettype none

`include "replay_params.svh"

module replay_store_tb
  import replay_pkg::*;
();

  localparam int FULL_HIGH = (1 << `REPLAY_ADDR_W) - 1;

  logic                      clk;
  logic                      arst_n;
  logic                      in_valid;
  logic [`REPLAY_WORD_W-1:0] in_data;
  logic                      in_full;
  logic                      reg_wr;
  logic [`REPLAY_REG_AW-1:0] reg_addr;
  logic [`REPLAY_REG_DW-1:0] reg_wdata;
  logic [`REPLAY_REG_DW-1:0] reg_rdata;
  logic                      cal_done;
  logic                      mem_wr_full;
  logic                      mem_ad_w_n;
  logic                      mem_d_w_n;
  logic [`REPLAY_ADDR_W-1:0] mem_ad_wr;
  logic [`REPLAY_HALF_W-1:0] mem_dwl;
  logic [`REPLAY_HALF_W-1:0] mem_dwh;

  integer seed;

  // Memory model state and ordered write log
  logic [`REPLAY_WORD_W-1:0] mem_model [int];
  int                        log_addr [$];
  logic [`REPLAY_WORD_W-1:0] log_word [$];
  // Words in push order with the same index as the log
  logic [`REPLAY_WORD_W-1:0] exp_word [$];
  int                        blocked_strobes;
  int                        strobe_skew;
  logic                      was_blocked;

  replay_store replay_store_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .in_valid    (in_valid),
    .in_data     (in_data),
    .in_full     (in_full),
    .reg_wr      (reg_wr),
    .reg_addr    (reg_addr),
    .reg_wdata   (reg_wdata),
    .reg_rdata   (reg_rdata),
    .cal_done    (cal_done),
    .mem_wr_full (mem_wr_full),
    .mem_ad_w_n  (mem_ad_w_n),
    .mem_d_w_n   (mem_d_w_n),
    .mem_ad_wr   (mem_ad_wr),
    .mem_dwl     (mem_dwl),
    .mem_dwh     (mem_dwh)
  );

  always #5 clk = !clk;

  // SRAM model sampled mid-cycle where outputs are settled
  always @(negedge clk) begin
    if (mem_ad_w_n !== mem_d_w_n) begin
      strobe_skew++;
    end
    if (!mem_ad_w_n) begin
      mem_model[int'(mem_ad_wr)] = {mem_dwh, mem_dwl};
      log_addr.push_back(int'(mem_ad_wr));
      log_word.push_back({mem_dwh, mem_dwl});
      // Strobe follows the accept cycle by one
      if (was_blocked) begin
        blocked_strobes++;
      end
    end
    was_blocked = !cal_done || mem_wr_full;
  end

  task automatic stop_run();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [71:0] expected,
                       input logic [71:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
      stop_run();
    end
  endtask

  function automatic logic [71:0] random_word();
    logic [95:0] bits;
    bits = {$random(seed), $random(seed), $random(seed)};
    return bits[71:0];
  endfunction

  // Circular window step with both bounds inclusive
  function automatic int next_addr(input int a, input int low, input int high);
    return (a == high) ? low : a + 1;
  endfunction

  task automatic write_reg(input reg_addr_e addr, input logic [31:0] data);
    @(posedge clk);
    #1 reg_wr = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(posedge clk);
    #1 reg_wr = 1'b0;
  endtask

  // Combinational read data sampled at the falling edge
  task automatic read_reg(input reg_addr_e addr, output logic [31:0] data);
    @(posedge clk);
    #1 reg_addr = addr;
    @(negedge clk);
    data = reg_rdata;
  endtask

  task automatic push_words(input int n);
    logic [71:0] w;
    for (int i = 0; i < n; i++) begin
      w = random_word();
      exp_word.push_back(w);
      @(posedge clk);
      #1 in_valid = 1'b1;
      in_data = w;
    end
    @(posedge clk);
    #1 in_valid = 1'b0;
  endtask

  task automatic wait_log(input int target, input int limit);
    int cycles;
    cycles = 0;
    while (log_addr.size() < target) begin
      if (cycles == limit) begin
        $display("Timed out waiting for memory writes, got %0d of %0d",
                 log_addr.size(), target);
        stop_run();
      end
      @(posedge clk);
      cycles++;
    end
  endtask

  // Log entries against pushed words and expected addresses
  task automatic check_writes(input string name, input int start, input int n,
                              input int first, input int low, input int high);
    int a;
    a = first;
    for (int i = start; i < start + n; i++) begin
      check({name, " addr"}, a, log_addr[i]);
      check({name, " dwl"}, exp_word[i][35:0], log_word[i][35:0]);
      check({name, " dwh"}, exp_word[i][71:36], log_word[i][71:36]);
      a = next_addr(a, low, high);
    end
  endtask

  task automatic test_reset();
    logic [31:0] rd;
    @(negedge clk);
    check("test_reset ad_w_n", 1, mem_ad_w_n);
    check("test_reset d_w_n", 1, mem_d_w_n);
    check("test_reset in_full", 0, in_full);
    read_reg(REG_WORD_COUNT, rd);
    check("test_reset count", 0, rd);
    read_reg(REG_WR_PTR, rd);
    check("test_reset wr_ptr", 0, rd);
  endtask

  task automatic test_sequential();
    logic [31:0] rd;
    int base;
    base = log_addr.size();
    push_words(8);
    wait_log(base + 8, 100);
    check_writes("test_sequential", base, 8, 0, 0, FULL_HIGH);
    read_reg(REG_WORD_COUNT, rd);
    check("test_sequential count", 8, rd);
  endtask

  task automatic test_backpressure();
    logic [31:0] rd;
    int base;
    int cycles;
    base = log_addr.size();
    @(posedge clk);
    #1 cal_done = 1'b0;
    push_words(16);
    @(negedge clk);
    check("test_backpressure in_full", 1, in_full);
    check("test_backpressure held", base, log_addr.size());
    // Release calibration and jitter the memory full flag
    cycles = 0;
    while (log_addr.size() < base + 16) begin
      if (cycles == 500) begin
        $display("Timed out draining the FIFO under random memory full");
        stop_run();
      end
      @(posedge clk);
      #1 cal_done = 1'b1;
      mem_wr_full = 1'($random(seed));
      cycles++;
    end
    mem_wr_full = 1'b0;
    check_writes("test_backpressure", base, 16, 8, 0, FULL_HIGH);
    check("test_backpressure blocked", 0, blocked_strobes);
    read_reg(REG_WORD_COUNT, rd);
    check("test_backpressure count", 24, rd);
  endtask

  task automatic test_wrap();
    logic [31:0] rd;
    logic [71:0] last_word [int];
    int base;
    int a;
    write_reg(REG_ADDR_LOW, 4);
    write_reg(REG_ADDR_HIGH, 7);
    // Enable with a soft reset to reload the pointer
    write_reg(REG_CTRL, 3);
    repeat (2) @(posedge clk);
    read_reg(REG_WR_PTR, rd);
    check("test_wrap start ptr", 4, rd);
    base = log_addr.size();
    push_words(10);
    wait_log(base + 10, 100);
    check_writes("test_wrap", base, 10, 4, 4, 7);
    // Last word written wins at each address
    a = 4;
    for (int i = 0; i < 10; i++) begin
      last_word[a] = exp_word[base + i];
      a = next_addr(a, 4, 7);
    end
    for (int k = 4; k <= 7; k++) begin
      check("test_wrap memory", last_word[k], mem_model[k]);
    end
    read_reg(REG_WORD_COUNT, rd);
    check("test_wrap count", 10, rd);
  endtask

  task automatic test_soft_reset();
    logic [31:0] rd;
    int base;
    base = log_addr.size();
    write_reg(REG_CTRL, 0);
    push_words(16);
    repeat (3) @(posedge clk);
    check("test_soft_reset disabled", base, log_addr.size());
    // Flush with enable still off and enable again after
    write_reg(REG_CTRL, 2);
    write_reg(REG_CTRL, 1);
    repeat (8) @(posedge clk);
    @(negedge clk);
    check("test_soft_reset in_full", 0, in_full);
    check("test_soft_reset no write", base, log_addr.size());
    read_reg(REG_WORD_COUNT, rd);
    check("test_soft_reset count", 0, rd);
    read_reg(REG_WR_PTR, rd);
    check("test_soft_reset wr_ptr", 4, rd);
    // cal_done high and FIFO empty
    read_reg(REG_STATUS, rd);
    check("test_soft_reset status", 3, rd);
  endtask

  initial begin
    seed            = 61;
    blocked_strobes = 0;
    strobe_skew     = 0;
    was_blocked     = 1'b0;
    clk             = 1'b0;
    arst_n          = 1'b0;
    in_valid        = 1'b0;
    in_data         = '0;
    reg_wr          = 1'b0;
    reg_addr        = '0;
    reg_wdata       = '0;
    cal_done        = 1'b1;
    mem_wr_full     = 1'b0;
    repeat (3) @(posedge clk);
    #1 arst_n = 1'b1;
    test_reset();
    test_sequential();
    test_backpressure();
    test_wrap();
    test_soft_reset();
    check("address and data strobes aligned", 0, strobe_skew);
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/fifo_to_mem.sv */
`default_nettype none

`include "replay_params.svh"

module fifo_to_mem
  import replay_pkg::*;
(
  input  wire logic                      clk,
  input  wire logic                      arst_n,
  input  wire logic                      cal_done,
  store_cfg_if.user                      cfg,
  input  wire logic [`REPLAY_WORD_W-1:0] head,
  input  wire logic                      empty,
  output logic                           pop,
  mem_write_if.writer                    mem
);

  localparam int unsigned BURST_LEN = `REPLAY_BURST_LEN;

  logic                      accept;
  logic                      strobe_now;
  logic                      strobe_n;
  logic [`REPLAY_ADDR_W-1:0] ptr;
  wr_phase_e                 phase;

  // Write rule, one word per clock at most
  assign accept = !empty && !mem.wr_full && cal_done && cfg.enable && !cfg.soft_rst;
  assign pop    = accept;

  // Burst 4 strobes only the first word of each pair
  assign strobe_now = accept && ((BURST_LEN == 2) || (phase == PHASE_FIRST));

  // Address and data strobes move together
  assign mem.ad_w_n = strobe_n;
  assign mem.d_w_n  = strobe_n;
  assign cfg.wr_ptr = ptr;

  // Split word and address, registered alongside the strobe
  always_ff @(posedge clk) begin
    if (accept) begin
      mem.dwl <= head[`REPLAY_HALF_W-1:0];
      mem.dwh <= head[`REPLAY_WORD_W-1:`REPLAY_HALF_W];
      // Burst 4 addresses pairs of words
      mem.ad_wr <= (BURST_LEN == 4) ? (ptr >> 1) : ptr;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      strobe_n       <= 1'b1;
      cfg.word_pulse <= 1'b0;
      ptr            <= '0;
      phase          <= PHASE_FIRST;
    end else if (cfg.soft_rst) begin
      strobe_n       <= 1'b1;
      cfg.word_pulse <= 1'b0;
      ptr            <= cfg.addr_low;
      phase          <= PHASE_FIRST;
    end else begin
      strobe_n       <= !strobe_now;
      cfg.word_pulse <= accept;
      if (accept) begin
        // Circular window, inclusive of both bounds
        if (ptr == cfg.addr_high) begin
          ptr <= cfg.addr_low;
        end else begin
          ptr <= ptr + 1'b1;
        end
        phase <= (phase == PHASE_FIRST) ? PHASE_SECOND : PHASE_FIRST;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/ingress_fifo.sv */
`default_nettype none

`include "replay_params.svh"

module ingress_fifo (
  input  wire logic                      clk,
  input  wire logic                      arst_n,
  store_cfg_if.user                      cfg,
  input  wire logic                      push,
  input  wire logic [`REPLAY_WORD_W-1:0] push_data,
  output logic                           full,
  input  wire logic                      pop,
  output logic      [`REPLAY_WORD_W-1:0] head,
  output logic                           empty
);

  localparam int unsigned DEPTH = `REPLAY_FIFO_DEPTH;

  logic [`REPLAY_WORD_W-1:0]  storage [DEPTH];
  logic [`REPLAY_FIFO_AW-1:0] wr_idx;
  logic [`REPLAY_FIFO_AW-1:0] rd_idx;
  // One extra bit so a full FIFO is distinct from empty
  logic [`REPLAY_FIFO_AW:0]   count;
  logic                       do_push;
  logic                       do_pop;

  assign full  = (count == (`REPLAY_FIFO_AW+1)'(DEPTH));
  assign empty = (count == '0);

  // Pushes while full or during a flush are dropped
  assign do_push = push && !full && !cfg.soft_rst;
  assign do_pop  = pop && !empty;

  // Oldest word always presented, valid while not empty
  assign head = storage[rd_idx];

  always_ff @(posedge clk) begin
    if (do_push) begin
      storage[wr_idx] <= push_data;
    end
  end

  // Pointers wrap on their own since depth is a power of two
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_idx <= '0;
      rd_idx <= '0;
      count  <= '0;
    end else if (cfg.soft_rst) begin
      // Flush, stored data is left behind
      wr_idx <= '0;
      rd_idx <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_idx <= wr_idx + 1'b1;
      end
      if (do_pop) begin
        rd_idx <= rd_idx + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/replay_params.svh */
`ifndef REPLAY_PARAMS_SVH
`define REPLAY_PARAMS_SVH

// Ingress word and its two memory halves
`define REPLAY_WORD_W 72
`define REPLAY_HALF_W 36

// SRAM write address width
`define REPLAY_ADDR_W 19

// Ingress FIFO geometry, depth must be a power of two
`define REPLAY_FIFO_DEPTH 16
`define REPLAY_FIFO_AW 4

// Memory burst length, 2 or 4
`define REPLAY_BURST_LEN 2

// Host register bus
`define REPLAY_REG_AW 3
`define REPLAY_REG_DW 32

`endif

/* verilog/replay_pkg.sv */
`default_nettype none

`include "replay_params.svh"

package replay_pkg;

  // Host register map
  typedef enum logic [`REPLAY_REG_AW-1:0] {
    REG_CTRL       = 3'd0, // bit 0 enable, bit 1 soft reset (write one)
    REG_ADDR_LOW   = 3'd1,
    REG_ADDR_HIGH  = 3'd2,
    REG_WORD_COUNT = 3'd3, // read only
    REG_WR_PTR     = 3'd4, // read only
    REG_STATUS     = 3'd5  // read only
  } reg_addr_e;

  // Writer burst phase, only relevant in burst 4
  typedef enum logic {
    PHASE_FIRST  = 1'b0,
    PHASE_SECOND = 1'b1
  } wr_phase_e;

endpackage

`default_nettype wire

/* verilog/replay_regs.sv */
`default_nettype none

`include "replay_params.svh"

module replay_regs
  import replay_pkg::*;
(
  input  wire logic                      clk,
  input  wire logic                      arst_n,
  input  wire logic                      cal_done,
  input  wire logic                      fifo_empty,
  input  wire logic                      reg_wr,
  input  wire logic [`REPLAY_REG_AW-1:0] reg_addr,
  input  wire logic [`REPLAY_REG_DW-1:0] reg_wdata,
  output logic      [`REPLAY_REG_DW-1:0] reg_rdata,
  store_cfg_if.regs                      cfg
);

  reg_addr_e                 addr_e;
  logic [`REPLAY_REG_DW-1:0] word_count;

  assign addr_e = reg_addr_e'(reg_addr);

  // Host writes land on the next edge
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cfg.enable    <= 1'b1;
      cfg.soft_rst  <= 1'b0;
      cfg.addr_low  <= '0;
      cfg.addr_high <= '1;
    end else begin
      // Soft reset lasts one cycle
      cfg.soft_rst <= reg_wr && (addr_e == REG_CTRL) && reg_wdata[1];
      if (reg_wr) begin
        case (addr_e)
          REG_CTRL:      cfg.enable    <= reg_wdata[0];
          REG_ADDR_LOW:  cfg.addr_low  <= reg_wdata[`REPLAY_ADDR_W-1:0];
          REG_ADDR_HIGH: cfg.addr_high <= reg_wdata[`REPLAY_ADDR_W-1:0];
          default: ;
        endcase
      end
    end
  end

  // Written-word counter, cleared along with the datapath
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      word_count <= '0;
    end else if (cfg.soft_rst) begin
      word_count <= '0;
    end else if (cfg.word_pulse) begin
      word_count <= word_count + 1'b1;
    end
  end

  // Read mux, unmapped addresses read zero
  always_comb begin
    reg_rdata = '0;
    case (addr_e)
      REG_CTRL:       reg_rdata[0] = cfg.enable;
      REG_ADDR_LOW:   reg_rdata[`REPLAY_ADDR_W-1:0] = cfg.addr_low;
      REG_ADDR_HIGH:  reg_rdata[`REPLAY_ADDR_W-1:0] = cfg.addr_high;
      REG_WORD_COUNT: reg_rdata = word_count;
      REG_WR_PTR:     reg_rdata[`REPLAY_ADDR_W-1:0] = cfg.wr_ptr;
      REG_STATUS: begin
        reg_rdata[0] = cal_done;
        reg_rdata[1] = fifo_empty;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/replay_store.sv */
`default_nettype none

`include "replay_params.svh"

module replay_store (
  input  wire logic                      clk,
  input  wire logic                      arst_n,
  // Host ingress stream
  input  wire logic                      in_valid,
  input  wire logic [`REPLAY_WORD_W-1:0] in_data,
  output logic                           in_full,
  // Host register bus
  input  wire logic                      reg_wr,
  input  wire logic [`REPLAY_REG_AW-1:0] reg_addr,
  input  wire logic [`REPLAY_REG_DW-1:0] reg_wdata,
  output logic      [`REPLAY_REG_DW-1:0] reg_rdata,
  // SRAM write side
  input  wire logic                      cal_done,
  input  wire logic                      mem_wr_full,
  output logic                           mem_ad_w_n,
  output logic                           mem_d_w_n,
  output logic      [`REPLAY_ADDR_W-1:0] mem_ad_wr,
  output logic      [`REPLAY_HALF_W-1:0] mem_dwl,
  output logic      [`REPLAY_HALF_W-1:0] mem_dwh
);

  logic                      fifo_pop;
  logic                      fifo_empty;
  logic [`REPLAY_WORD_W-1:0] fifo_head;

  store_cfg_if cfg_bus ();
  mem_write_if mem_bus ();

  // Memory port onto plain pins
  assign mem_bus.wr_full = mem_wr_full;
  assign mem_ad_w_n      = mem_bus.ad_w_n;
  assign mem_d_w_n       = mem_bus.d_w_n;
  assign mem_ad_wr       = mem_bus.ad_wr;
  assign mem_dwl         = mem_bus.dwl;
  assign mem_dwh         = mem_bus.dwh;

  ingress_fifo ingress_fifo_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .cfg       (cfg_bus),
    .push      (in_valid),
    .push_data (in_data),
    .full      (in_full),
    .pop       (fifo_pop),
    .head      (fifo_head),
    .empty     (fifo_empty)
  );

  fifo_to_mem fifo_to_mem_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .cal_done (cal_done),
    .cfg      (cfg_bus),
    .head     (fifo_head),
    .empty    (fifo_empty),
    .pop      (fifo_pop),
    .mem      (mem_bus)
  );

  replay_regs replay_regs_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .cal_done   (cal_done),
    .fifo_empty (fifo_empty),
    .reg_wr     (reg_wr),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .reg_rdata  (reg_rdata),
    .cfg        (cfg_bus)
  );

endmodule

`default_nettype wire

/* verilog/store_ifs.sv */
`default_nettype none

`include "replay_params.svh"

// Control from the register block, status back from the writer
interface store_cfg_if;
  logic                      soft_rst;
  logic                      enable;
  logic [`REPLAY_ADDR_W-1:0] addr_low;
  logic [`REPLAY_ADDR_W-1:0] addr_high;
  logic                      word_pulse;
  logic [`REPLAY_ADDR_W-1:0] wr_ptr;

  modport regs (output soft_rst, enable, addr_low, addr_high,
                input  word_pulse, wr_ptr);
  modport user (input  soft_rst, enable, addr_low, addr_high,
                output word_pulse, wr_ptr);
endinterface

// SRAM write port, strobes active low
interface mem_write_if;
  logic                      ad_w_n;
  logic                      d_w_n;
  logic [`REPLAY_ADDR_W-1:0] ad_wr;
  logic [`REPLAY_HALF_W-1:0] dwl;
  logic [`REPLAY_HALF_W-1:0] dwh;
  logic                      wr_full;

  modport writer (output ad_w_n, d_w_n, ad_wr, dwl, dwh,
                  input  wr_full);
endinterface

`default_nettype wire
